// ==== list.f ====
verilog/cpu_pkg.sv
verilog/fwd_if.sv
verilog/pipe_reg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/pipe_cpu.sv
sim/cpu_properties.sv
sim/cpu_checker.sv
sim/tb_pipe_cpu.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_pipe_cpu
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = Simulation finished: PASS

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_pipe_cpu.sv ====
`timescale 1ns/1ps

module tb_pipe_cpu;

    localparam int MEM_WORDS      = 64;
    localparam int MEM_AW         = 6;
    localparam int PROG_LEN       = 27;
    localparam int TIMEOUT_CYCLES = 8 * PROG_LEN + 50;
    localparam int SETTLE_CYCLES  = 16;

    logic             clk;
    logic             rst;
    cpu_pkg::word_t   imem_addr;
    cpu_pkg::word_t   imem_rdata;
    cpu_pkg::word_t   dmem_addr;
    cpu_pkg::word_t   dmem_wdata;
    cpu_pkg::word_t   dmem_rdata;
    logic             dmem_read;
    logic             dmem_write;
    cpu_pkg::reg_id_t reg_wa;
    cpu_pkg::word_t   reg_wdata;
    logic             regwrite;

    cpu_pkg::word_t   imem [MEM_WORDS];
    cpu_pkg::word_t   dmem [MEM_WORDS];
    integer           seed;
    int               cycle_count;
    logic             timed_out;
    logic             done;
    int               err_count;
    int               writes_seen;
    int               writes_expected;
    int               stores_seen;
    int               stores_expected;

    always #2 clk = ~clk;

    pipe_cpu u_dut (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .dmem_rdata (dmem_rdata),
        .reg_wa     (reg_wa),
        .reg_wdata  (reg_wdata),
        .regwrite   (regwrite)
    );

    cpu_checker #(.MEM_WORDS(MEM_WORDS), .STEP_LIMIT(8 * PROG_LEN)) u_chk (
        .clk             (clk),
        .rst             (rst),
        .regwrite        (regwrite),
        .reg_wa          (reg_wa),
        .reg_wdata       (reg_wdata),
        .dmem_write      (dmem_write),
        .dmem_addr       (dmem_addr),
        .dmem_wdata      (dmem_wdata),
        .prog            (imem),
        .mem_init        (dmem),
        .done            (done),
        .err_count       (err_count),
        .writes_seen     (writes_seen),
        .writes_expected (writes_expected),
        .stores_seen     (stores_seen),
        .stores_expected (stores_expected)
    );

    // ==============================
    // Memory models
    // ==============================
    // Read data settles half a cycle after the address moves
    // Data memory returns zero unless a read is requested
    always @(negedge clk)
    begin
        imem_rdata <= imem[imem_addr[MEM_AW+1:2]];
        dmem_rdata <= dmem_read ? dmem[dmem_addr[MEM_AW+1:2]] : '0;
    end

    always @(posedge clk)
    begin
        if (dmem_write)
            dmem[dmem_addr[MEM_AW+1:2]] <= dmem_wdata;
    end

    function automatic cpu_pkg::word_t rtype_word(input logic [5:0] func, input int rd,
                                                  input int rs, input int rt);
        return {cpu_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'b0, func};
    endfunction

    function automatic cpu_pkg::word_t itype_word(input logic [5:0] op, input int rt,
                                                  input int rs, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            imem[i] = '0;
            dmem[i] = cpu_pkg::word_t'(i) * 32'h0101_0101 ^ 32'hc3a5_0f00;
        end
        imem[0]  = itype_word(cpu_pkg::OP_ADDI, 1, 0, $random(seed));
        imem[1]  = itype_word(cpu_pkg::OP_ADDI, 2, 0, $random(seed));
        imem[2]  = itype_word(cpu_pkg::OP_ADDI, 3, 0, $random(seed));
        imem[3]  = itype_word(cpu_pkg::OP_ADDI, 4, 0, $random(seed));
        // Dependent chain at distances one and two
        imem[4]  = rtype_word(cpu_pkg::FUNC_ADD, 5, 1, 2);
        imem[5]  = rtype_word(cpu_pkg::FUNC_SUB, 6, 5, 3);
        imem[6]  = rtype_word(cpu_pkg::FUNC_AND, 7, 5, 4);
        imem[7]  = rtype_word(cpu_pkg::FUNC_OR, 8, 6, 7);
        imem[8]  = rtype_word(cpu_pkg::FUNC_SLT, 9, 6, 7);
        imem[9]  = rtype_word(cpu_pkg::FUNC_SLT, 10, 7, 6);
        imem[10] = rtype_word(cpu_pkg::FUNC_ADD, 0, 1, 2);
        // Store, load back, then load-use twice
        imem[11] = itype_word(cpu_pkg::OP_SW, 8, 0, 8);
        imem[12] = itype_word(cpu_pkg::OP_LW, 11, 0, 8);
        imem[13] = rtype_word(cpu_pkg::FUNC_ADD, 12, 11, 1);
        imem[14] = itype_word(cpu_pkg::OP_LW, 13, 0, 20);
        imem[15] = rtype_word(cpu_pkg::FUNC_SUB, 14, 13, 12);
        imem[16] = rtype_word(cpu_pkg::FUNC_OR, 15, 14, 0);
        // Branch not taken, then taken over two
        imem[17] = itype_word(cpu_pkg::OP_ADDI, 16, 0, 1);
        imem[18] = itype_word(cpu_pkg::OP_BEQ, 0, 16, 2);
        imem[19] = itype_word(cpu_pkg::OP_ADDI, 17, 16, 5);
        imem[20] = itype_word(cpu_pkg::OP_BEQ, 17, 17, 2);
        imem[21] = itype_word(cpu_pkg::OP_ADDI, 18, 0, 7);
        imem[22] = itype_word(cpu_pkg::OP_ADDI, 19, 0, 9);
        imem[23] = rtype_word(cpu_pkg::FUNC_ADD, 20, 17, 16);
        imem[24] = itype_word(cpu_pkg::OP_SW, 20, 0, 12);
        imem[25] = rtype_word(cpu_pkg::FUNC_ADD, 21, 20, 14);
        imem[PROG_LEN-1] = itype_word(cpu_pkg::OP_BEQ, 0, 0, -1);
    endtask

    initial
    begin
        clk         = 1'b0;
        rst         = 1'b1;
        imem_rdata  = '0;
        dmem_rdata  = '0;
        seed        = 32'h3f06;
        cycle_count = 0;
        timed_out   = 1'b0;
        load_program();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        while (!done && cycle_count < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            cycle_count++;
        end
        timed_out = !done;
        if (timed_out)
            $display("Timeout after %0d cycles: expected writes or stores never appeared",
                     cycle_count);
        else
            repeat (SETTLE_CYCLES) @(negedge clk);
        $display("Register writes %0d of %0d, stores %0d of %0d, errors %0d, assertion errors %0d",
                 writes_seen, writes_expected, stores_seen, stores_expected, err_count,
                 u_dut.u_props.assert_errors);
        if (timed_out || err_count != 0 || u_dut.u_props.assert_errors != 0)
            $display("Simulation finished: FAIL");
        else
            $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== sim/cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker #(
    parameter int MEM_WORDS  = 64,
    parameter int STEP_LIMIT = 256
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             regwrite,
    input  cpu_pkg::reg_id_t reg_wa,
    input  cpu_pkg::word_t   reg_wdata,
    input  logic             dmem_write,
    input  cpu_pkg::word_t   dmem_addr,
    input  cpu_pkg::word_t   dmem_wdata,
    input  cpu_pkg::word_t   prog [MEM_WORDS],
    input  cpu_pkg::word_t   mem_init [MEM_WORDS],
    output logic             done,
    output int               err_count,
    output int               writes_seen,
    output int               writes_expected,
    output int               stores_seen,
    output int               stores_expected
);

    cpu_pkg::word_t   model_regs [32];
    cpu_pkg::word_t   model_mem [MEM_WORDS];
    cpu_pkg::reg_id_t exp_wa [$];
    cpu_pkg::word_t   exp_wd [$];
    cpu_pkg::word_t   exp_sa [$];
    cpu_pkg::word_t   exp_sd [$];

    function automatic int mem_index(input cpu_pkg::word_t addr);
        return int'(addr >> 2) % MEM_WORDS;
    endfunction

    // r0 stays zero and never shows up as a write
    function automatic void retire_write(input cpu_pkg::reg_id_t rd, input cpu_pkg::word_t val);
        if (rd != '0)
        begin
            model_regs[rd] = val;
            exp_wa.push_back(rd);
            exp_wd.push_back(val);
        end
    endfunction

    // ==============================
    // Reference ISA model
    // ==============================
    function automatic void run_reference();
        cpu_pkg::word_t   instr;
        cpu_pkg::word_t   a;
        cpu_pkg::word_t   b;
        cpu_pkg::word_t   imm;
        cpu_pkg::word_t   res;
        cpu_pkg::reg_id_t rs;
        cpu_pkg::reg_id_t rt;
        cpu_pkg::reg_id_t rd;
        logic             valid;
        logic             stop;
        int               pc;
        int               next;
        int               steps;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        for (int i = 0; i < MEM_WORDS; i++)
            model_mem[i] = mem_init[i];
        pc    = 0;
        steps = 0;
        stop  = 1'b0;
        while (!stop && pc >= 0 && pc < MEM_WORDS && steps < STEP_LIMIT)
        begin
            instr = prog[pc];
            rs    = instr[25:21];
            rt    = instr[20:16];
            rd    = instr[15:11];
            a     = model_regs[rs];
            b     = model_regs[rt];
            imm   = {{16{instr[15]}}, instr[15:0]};
            next  = pc + 1;
            steps++;
            case (instr[31:26])
                cpu_pkg::OP_RTYPE:
                begin
                    valid = 1'b1;
                    res   = '0;
                    case (instr[5:0])
                        cpu_pkg::FUNC_ADD: res = a + b;
                        cpu_pkg::FUNC_SUB: res = a - b;
                        cpu_pkg::FUNC_AND: res = a & b;
                        cpu_pkg::FUNC_OR:  res = a | b;
                        cpu_pkg::FUNC_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:           valid = 1'b0;
                    endcase
                    if (valid)
                        retire_write(rd, res);
                end
                cpu_pkg::OP_ADDI: retire_write(rt, a + imm);
                cpu_pkg::OP_LW:   retire_write(rt, model_mem[mem_index(a + imm)]);
                cpu_pkg::OP_SW:
                begin
                    model_mem[mem_index(a + imm)] = b;
                    exp_sa.push_back(a + imm);
                    exp_sd.push_back(b);
                end
                cpu_pkg::OP_BEQ:
                begin
                    if (a == b)
                        next = pc + 1 + int'($signed(imm));
                    // Branch onto itself ends the program
                    stop = next == pc;
                end
                default:
                begin
                    // Not in the subset, acts as a no-op
                end
            endcase
            pc = next;
        end
    endfunction

    // ==============================
    // Comparison of write events
    // ==============================
    function automatic void check_write();
        if (writes_seen >= writes_expected)
        begin
            err_count++;
            $display("ERR %0t: unexpected register write r%0d = %h", $time, reg_wa, reg_wdata);
        end
        else
        begin
            if (reg_wa !== exp_wa[writes_seen] || reg_wdata !== exp_wd[writes_seen])
            begin
                err_count++;
                $display("ERR %0t: write %0d expected r%0d = %h, got r%0d = %h", $time,
                         writes_seen, exp_wa[writes_seen], exp_wd[writes_seen],
                         reg_wa, reg_wdata);
            end
            writes_seen++;
        end
    endfunction

    function automatic void check_store();
        if (stores_seen >= stores_expected)
        begin
            err_count++;
            $display("ERR %0t: unexpected store [%h] = %h", $time, dmem_addr, dmem_wdata);
        end
        else
        begin
            if (dmem_addr !== exp_sa[stores_seen] || dmem_wdata !== exp_sd[stores_seen])
            begin
                err_count++;
                $display("ERR %0t: store %0d expected [%h] = %h, got [%h] = %h", $time,
                         stores_seen, exp_sa[stores_seen], exp_sd[stores_seen],
                         dmem_addr, dmem_wdata);
            end
            stores_seen++;
        end
    endfunction

    initial
    begin
        done            = 1'b0;
        err_count       = 0;
        writes_seen     = 0;
        writes_expected = 0;
        stores_seen     = 0;
        stores_expected = 0;
        // Memory holds its initial image until reset ends
        @(negedge rst);
        run_reference();
        writes_expected = exp_wa.size();
        stores_expected = exp_sa.size();
        forever
        begin
            @(posedge clk);
            if (regwrite)
                check_write();
            if (dmem_write)
                check_store();
            done = writes_seen == writes_expected && stores_seen == stores_expected;
        end
    end

endmodule

// ==== sim/cpu_properties.sv ====
`timescale 1ns/1ps

module cpu_properties (
    input logic             clk,
    input logic             rst,
    input logic             dmem_read,
    input logic             dmem_write,
    input logic             regwrite,
    input cpu_pkg::reg_id_t reg_wa
);

    // Number of assertion failures so far
    int assert_errors = 0;

    // Load and store share one data port
    mem_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(dmem_read && dmem_write))
        else
        begin
            assert_errors++;
            $error("data memory read and write are high in the same cycle");
        end

    no_r0_write: assert property (@(posedge clk) disable iff (rst)
        regwrite |-> reg_wa != '0)
        else
        begin
            assert_errors++;
            $error("register write targets r0");
        end

    // Writes are cleared by the reset edge and stay low while it lasts
    quiet_in_reset: assert property (@(posedge clk)
        rst |=> (!regwrite && !dmem_write))
        else
        begin
            assert_errors++;
            $error("write seen while reset is asserted");
        end

endmodule

bind pipe_cpu cpu_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .dmem_read  (dmem_read),
    .dmem_write (dmem_write),
    .regwrite   (regwrite),
    .reg_wa     (reg_wa)
);

// ==== verilog/pipe_cpu.sv ====
`timescale 1ns/1ps

module pipe_cpu (
    input  logic              clk,
    input  logic              rst,
    output cpu_pkg::word_t    imem_addr,
    input  cpu_pkg::word_t    imem_rdata,
    output cpu_pkg::word_t    dmem_addr,
    output cpu_pkg::word_t    dmem_wdata,
    output logic              dmem_read,
    output logic              dmem_write,
    input  cpu_pkg::word_t    dmem_rdata,
    output cpu_pkg::reg_id_t  reg_wa,
    output cpu_pkg::word_t    reg_wdata,
    output logic              regwrite
);

    logic              stall;
    logic              taken;
    cpu_pkg::word_t    target;
    cpu_pkg::if_id_t   if_id_d;
    cpu_pkg::if_id_t   if_id_q;
    cpu_pkg::id_ex_t   id_ex_d;
    cpu_pkg::id_ex_t   id_ex_q;
    cpu_pkg::ex_mem_t  ex_mem_d;
    cpu_pkg::ex_mem_t  ex_mem_q;

    fwd_if u_fwd ();

    // ==============================
    // Stages and stage registers
    // ==============================
    fetch_stage u_fetch (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .taken      (taken),
        .target     (target),
        .imem_rdata (imem_rdata),
        .imem_addr  (imem_addr),
        .if_id_d    (if_id_d)
    );

    pipe_reg #(.T(cpu_pkg::if_id_t)) u_if_id (
        .clk   (clk),
        .rst   (rst),
        .hold  (stall),
        .flush (taken),
        .d     (if_id_d),
        .q     (if_id_q)
    );

    decode_stage u_decode (
        .clk     (clk),
        .rst     (rst),
        .if_id_q (if_id_q),
        .id_ex_q (id_ex_q),
        .fwd     (u_fwd.sink),
        .stall   (stall),
        .id_ex_d (id_ex_d)
    );

    // Load-use bubble enters here
    pipe_reg #(.T(cpu_pkg::id_ex_t)) u_id_ex (
        .clk   (clk),
        .rst   (rst),
        .hold  (1'b0),
        .flush (stall || taken),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    execute_stage u_execute (
        .id_ex_q  (id_ex_q),
        .fwd      (u_fwd.sink),
        .ex_mem_d (ex_mem_d)
    );

    pipe_reg #(.T(cpu_pkg::ex_mem_t)) u_ex_mem (
        .clk   (clk),
        .rst   (rst),
        .hold  (1'b0),
        .flush (taken),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    mem_wb_stage u_mem_wb (
        .clk        (clk),
        .rst        (rst),
        .ex_mem_q   (ex_mem_q),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .taken      (taken),
        .target     (target),
        .fwd        (u_fwd.source),
        .reg_wa     (reg_wa),
        .reg_wdata  (reg_wdata),
        .regwrite   (regwrite)
    );

endmodule

// ==== verilog/mem_wb_stage.sv ====
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::ex_mem_t  ex_mem_q,
    input  cpu_pkg::word_t    dmem_rdata,
    output cpu_pkg::word_t    dmem_addr,
    output cpu_pkg::word_t    dmem_wdata,
    output logic              dmem_read,
    output logic              dmem_write,
    output logic              taken,
    output cpu_pkg::word_t    target,
    fwd_if.source             fwd,
    output cpu_pkg::reg_id_t  reg_wa,
    output cpu_pkg::word_t    reg_wdata,
    output logic              regwrite
);

    logic             wb_regwrite;
    logic             wb_memtoreg;
    cpu_pkg::word_t   wb_result;
    cpu_pkg::word_t   wb_load;
    cpu_pkg::reg_id_t wb_wa;
    cpu_pkg::word_t   wb_data;

    // ==============================
    // Memory stage
    // ==============================
    assign taken  = ex_mem_q.ctrl.branch && ex_mem_q.zero;
    assign target = ex_mem_q.target;

    assign dmem_addr  = ex_mem_q.result;
    assign dmem_wdata = ex_mem_q.store_data;
    assign dmem_read  = ex_mem_q.ctrl.memread;
    assign dmem_write = ex_mem_q.ctrl.memwrite;

    assign fwd.mem_regwrite = ex_mem_q.ctrl.regwrite;
    assign fwd.mem_wa       = ex_mem_q.wa;
    assign fwd.mem_result   = ex_mem_q.result;

    // MEM/WB register
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_regwrite <= 1'b0;
            wb_memtoreg <= 1'b0;
        end
        else
        begin
            wb_regwrite <= ex_mem_q.ctrl.regwrite;
            wb_memtoreg <= ex_mem_q.ctrl.memtoreg;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_result <= ex_mem_q.result;
        wb_load   <= dmem_rdata;
        wb_wa     <= ex_mem_q.wa;
    end

    // ==============================
    // Writeback
    // ==============================
    assign wb_data = wb_memtoreg ? wb_load : wb_result;

    assign fwd.wb_regwrite = wb_regwrite;
    assign fwd.wb_wa       = wb_wa;
    assign fwd.wb_data     = wb_data;

    assign reg_wa    = wb_wa;
    assign reg_wdata = wb_data;
    assign regwrite  = wb_regwrite;

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  cpu_pkg::id_ex_t   id_ex_q,
    fwd_if.sink               fwd,
    output cpu_pkg::ex_mem_t  ex_mem_d
);

    cpu_pkg::word_t   opa;
    cpu_pkg::word_t   fwd_b;
    cpu_pkg::word_t   opb;
    cpu_pkg::word_t   result;
    cpu_pkg::word_t   imm_sh2;
    cpu_pkg::reg_id_t dest;
    logic             slt;

    // Youngest producer wins, EX/MEM before MEM/WB
    function automatic cpu_pkg::word_t fwd_sel(
        input cpu_pkg::reg_id_t src,
        input cpu_pkg::word_t   reg_val
    );
        if (fwd.mem_regwrite && fwd.mem_wa != '0 && fwd.mem_wa == src)
            return fwd.mem_result;
        else if (fwd.wb_regwrite && fwd.wb_wa != '0 && fwd.wb_wa == src)
            return fwd.wb_data;
        return reg_val;
    endfunction

    // ==============================
    // Operand select
    // ==============================
    always_comb
    begin
        opa   = fwd_sel(id_ex_q.rs, id_ex_q.rdata_a);
        fwd_b = fwd_sel(id_ex_q.rt, id_ex_q.rdata_b);
    end

    assign opb = id_ex_q.alusrc ? id_ex_q.imm : fwd_b;

    // ==============================
    // ALU
    // ==============================
    assign slt = $signed(opa) < $signed(opb);

    always_comb
    begin
        case (id_ex_q.alu_op)
            cpu_pkg::ALU_ADD: result = opa + opb;
            cpu_pkg::ALU_SUB: result = opa - opb;
            cpu_pkg::ALU_AND: result = opa & opb;
            cpu_pkg::ALU_OR:  result = opa | opb;
            cpu_pkg::ALU_SLT: result = {{(cpu_pkg::XLEN-1){1'b0}}, slt};
            default:          result = opa + opb;
        endcase
    end

    // Destination and branch target
    assign dest    = id_ex_q.regdst ? id_ex_q.rd : id_ex_q.rt;
    assign imm_sh2 = {id_ex_q.imm[cpu_pkg::XLEN-3:0], 2'b00};

    always_comb
    begin
        ex_mem_d.ctrl          = id_ex_q.ctrl;
        // A write to r0 is dropped here so it never reaches writeback
        ex_mem_d.ctrl.regwrite = id_ex_q.ctrl.regwrite && dest != '0;
        ex_mem_d.result        = result;
        ex_mem_d.zero          = result == '0;
        ex_mem_d.store_data    = fwd_b;
        ex_mem_d.target        = id_ex_q.next_pc + imm_sh2;
        ex_mem_d.wa            = dest;
    end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::if_id_t   if_id_q,
    input  cpu_pkg::id_ex_t   id_ex_q,
    fwd_if.sink               fwd,
    output logic              stall,
    output cpu_pkg::id_ex_t   id_ex_d
);

    logic [5:0]       opcode;
    logic [5:0]       func;
    cpu_pkg::reg_id_t rs;
    cpu_pkg::reg_id_t rt;
    cpu_pkg::reg_id_t rd;
    cpu_pkg::word_t   imm_sext;
    cpu_pkg::ctrl_t   ctrl;
    cpu_pkg::alu_op_t alu_op;
    logic             alusrc;
    logic             regdst;
    cpu_pkg::word_t   regs [32];
    cpu_pkg::word_t   rdata_a;
    cpu_pkg::word_t   rdata_b;

    // ==============================
    // Field breakout
    // ==============================
    assign opcode   = if_id_q.instr[31:26];
    assign rs       = if_id_q.instr[25:21];
    assign rt       = if_id_q.instr[20:16];
    assign rd       = if_id_q.instr[15:11];
    assign func     = if_id_q.instr[5:0];
    assign imm_sext = {{16{if_id_q.instr[15]}}, if_id_q.instr[15:0]};

    // ==============================
    // Control decode
    // ==============================
    always_comb
    begin
        ctrl   = '0;
        alu_op = cpu_pkg::ALU_ADD;
        alusrc = 1'b0;
        regdst = 1'b0;
        case (opcode)
            cpu_pkg::OP_RTYPE:
            begin
                regdst = 1'b1;
                ctrl.regwrite = 1'b1;
                case (func)
                    cpu_pkg::FUNC_ADD: alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FUNC_SUB: alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FUNC_AND: alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FUNC_OR:  alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FUNC_SLT: alu_op = cpu_pkg::ALU_SLT;
                    // Unknown function, so a bubble (covers the all-zero word)
                    default:           ctrl.regwrite = 1'b0;
                endcase
            end
            cpu_pkg::OP_ADDI:
            begin
                alusrc = 1'b1;
                ctrl.regwrite = 1'b1;
            end
            cpu_pkg::OP_LW:
            begin
                alusrc = 1'b1;
                ctrl.regwrite = 1'b1;
                ctrl.memread  = 1'b1;
                ctrl.memtoreg = 1'b1;
            end
            cpu_pkg::OP_SW:
            begin
                alusrc = 1'b1;
                ctrl.memwrite = 1'b1;
            end
            cpu_pkg::OP_BEQ:
            begin
                alu_op = cpu_pkg::ALU_SUB;
                ctrl.branch = 1'b1;
            end
            default:
            begin
                ctrl = '0;
            end
        endcase
    end

    // ==============================
    // Register file
    // ==============================
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (fwd.wb_regwrite && fwd.wb_wa != '0)
        begin
            regs[fwd.wb_wa] <= fwd.wb_data;
        end
    end

    // Same-cycle write is visible to the read
    always_comb
    begin
        if (rs == '0)
            rdata_a = '0;
        else if (fwd.wb_regwrite && fwd.wb_wa == rs)
            rdata_a = fwd.wb_data;
        else
            rdata_a = regs[rs];
    end

    always_comb
    begin
        if (rt == '0)
            rdata_b = '0;
        else if (fwd.wb_regwrite && fwd.wb_wa == rt)
            rdata_b = fwd.wb_data;
        else
            rdata_b = regs[rt];
    end

    // Load in EX feeding this instruction
    assign stall = id_ex_q.ctrl.memread && (id_ex_q.rt == rs || id_ex_q.rt == rt);

    always_comb
    begin
        id_ex_d.ctrl    = ctrl;
        id_ex_d.alu_op  = alu_op;
        id_ex_d.alusrc  = alusrc;
        id_ex_d.regdst  = regdst;
        id_ex_d.next_pc = if_id_q.next_pc;
        id_ex_d.rdata_a = rdata_a;
        id_ex_d.rdata_b = rdata_b;
        id_ex_d.imm     = imm_sext;
        id_ex_d.rs      = rs;
        id_ex_d.rt      = rt;
        id_ex_d.rd      = rd;
    end

endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              taken,
    input  cpu_pkg::word_t    target,
    input  cpu_pkg::word_t    imem_rdata,
    output cpu_pkg::word_t    imem_addr,
    output cpu_pkg::if_id_t   if_id_d
);

    cpu_pkg::word_t pc;
    cpu_pkg::word_t pc_plus4;

    assign pc_plus4 = pc + cpu_pkg::word_t'(4);

    // Redirect first, then load-use hold, else sequential
    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= cpu_pkg::RESET_PC;
        else if (taken)
            pc <= target;
        else if (!stall)
            pc <= pc_plus4;
    end

    assign imem_addr = pc;

    // Instruction memory answers in the same cycle
    assign if_id_d.next_pc = pc_plus4;
    assign if_id_d.instr   = imem_rdata;

endmodule

// ==== verilog/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic hold,
    input  logic flush,
    input  T     d,
    output T     q
);

    // Flush wins over hold, and a cleared payload is a bubble
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            q <= '0;
        end
        else if (!hold)
        begin
            q <= d;
        end
    end

endmodule

// ==== verilog/fwd_if.sv ====
`timescale 1ns/1ps

interface fwd_if;

    // Write in the memory stage, from EX/MEM
    logic             mem_regwrite;
    cpu_pkg::reg_id_t mem_wa;
    cpu_pkg::word_t   mem_result;

    // Write in the writeback stage, from MEM/WB
    logic             wb_regwrite;
    cpu_pkg::reg_id_t wb_wa;
    cpu_pkg::word_t   wb_data;

    modport source (
        output mem_regwrite, mem_wa, mem_result,
        output wb_regwrite, wb_wa, wb_data
    );

    modport sink (
        input mem_regwrite, mem_wa, mem_result,
        input wb_regwrite, wb_wa, wb_data
    );

endinterface

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    // ==============================
    // Widths and basic types
    // ==============================
    localparam int XLEN  = 32;
    localparam int REG_W = 5;

    typedef logic [XLEN-1:0]  word_t;
    typedef logic [REG_W-1:0] reg_id_t;

    localparam word_t RESET_PC = '0;

    // ==============================
    // Instruction encoding
    // ==============================
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_SW    = 6'b101011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;

    localparam logic [5:0] FUNC_ADD = 6'b100000;
    localparam logic [5:0] FUNC_SUB = 6'b100010;
    localparam logic [5:0] FUNC_AND = 6'b100100;
    localparam logic [5:0] FUNC_OR  = 6'b100101;
    localparam logic [5:0] FUNC_SLT = 6'b101010;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    // ==============================
    // Stage register payloads
    // ==============================

    // All zeros is a bubble
    typedef struct packed {
        logic regwrite;
        logic memread;
        logic memwrite;
        logic memtoreg;
        logic branch;
    } ctrl_t;

    typedef struct packed {
        word_t next_pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t   ctrl;
        alu_op_t alu_op;
        logic    alusrc;
        logic    regdst;
        word_t   next_pc;
        word_t   rdata_a;
        word_t   rdata_b;
        word_t   imm;
        reg_id_t rs;
        reg_id_t rt;
        reg_id_t rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t   ctrl;
        word_t   result;
        logic    zero;
        word_t   store_data;
        word_t   target;
        reg_id_t wa;
    } ex_mem_t;

endpackage
